/* source/soc_bus_pkg.sv */
// Bus, byte lane, interrupt and GPIO widths with their vector types

package soc_bus_pkg;

  localparam int WORD_W = 16;    // Data bus width
  localparam int ADDR_W = 19;    // Word address, byte address bits 19..1
  localparam int SEL_W  = 2;     // One enable per byte lane
  localparam int IRQ_N  = 8;     // Interrupt request lines
  localparam int LED_W  = 10;
  localparam int SW_W   = 10;

  // Slave select bit positions
  localparam int SLV_GPIO   = 0;
  localparam int SLV_SYSCTL = 1;
  localparam int SLV_DEF    = 2;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [SEL_W-1:0]  sel_t;

  typedef logic [IRQ_N-1:0]         irq_t;
  typedef logic [$clog2(IRQ_N)-1:0] iid_t;

  // One-hot, default slave is the top bit
  typedef logic [SLV_DEF:0] slv_t;

  typedef logic [LED_W-1:0] led_t;
  typedef logic [SW_W-1:0]  sw_t;

endpackage

/* source/soc_map_pkg.sv */
// I/O map windows, system control lane, default read word and interrupt vector base

package soc_map_pkg;

  // Match words are {io flag, word address}, same layout as the request
  // Switches and LEDs, io 0xf100 - 0xf103
  localparam logic [soc_bus_pkg::ADDR_W:0] GPIO_BASE =
    20'b1_0000_1111_0001_0000_000;
  localparam logic [soc_bus_pkg::ADDR_W:0] GPIO_MASK =
    20'b1_0000_1111_1111_1111_110;

  // System control, word 0x60 of io space
  localparam logic [soc_bus_pkg::ADDR_W:0] SYSCTL_BASE =
    20'b1_0000_0000_0000_0110_000;
  localparam logic [soc_bus_pkg::ADDR_W:0] SYSCTL_MASK =
    20'b1_0000_1111_1111_1111_111;

  // Port 0x61 sits on the odd byte of word 0x60
  localparam int SYSCTL_LANE = 1;

  // Unmapped reads float high
  localparam soc_bus_pkg::word_t DEF_RDATA = 16'hffff;

  // Interrupt acknowledge returns this plus the line number
  localparam soc_bus_pkg::word_t INT_VEC_BASE = 16'h0008;

endpackage

/* source/io_addr_decode.sv */
// Address decoder turning a bus request into a one-hot slave select

`timescale 1ns/1ps

module io_addr_decode (
  input  logic               io_i,
  input  soc_bus_pkg::addr_t adr_i,
  input  soc_bus_pkg::sel_t  sel_i,
  output soc_bus_pkg::slv_t  slv_sel_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [ADDR_W:0] req;      // {io flag, word address}
  logic            gpio_hit;
  logic            sys_word;
  logic            sys_hit;

  assign req = {io_i, adr_i};

  // Base plus mask compare per window
  assign gpio_hit = (req & GPIO_MASK) == GPIO_BASE;
  assign sys_word = (req & SYSCTL_MASK) == SYSCTL_BASE;

  // Low lane of word 0x60 is not ours and falls through to default
  assign sys_hit = sys_word && sel_i[SYSCTL_LANE];

  always_comb begin
    slv_sel_o             = '0;
    slv_sel_o[SLV_GPIO]   = gpio_hit;
    slv_sel_o[SLV_SYSCTL] = sys_hit;
    slv_sel_o[SLV_DEF]    = !(gpio_hit || sys_hit);  // Catch everything else
  end

endmodule

/* source/gpio_port.sv */
// Switch input port and byte writable LED register with registered acknowledge

`timescale 1ns/1ps

module gpio_port (
  input  logic               clk,
  input  logic               rst_lck,
  input  logic               stb_i,
  input  logic               we_i,
  input  logic               adr0_i,   // Word bit, 0xf100 vs 0xf102
  input  soc_bus_pkg::sel_t  sel_i,
  input  soc_bus_pkg::word_t dat_i,
  input  soc_bus_pkg::sw_t   sw_i,
  output soc_bus_pkg::word_t dat_o,
  output logic               ack_o,
  output soc_bus_pkg::led_t  leds_o
);

  import soc_bus_pkg::*;

  logic ack_q;
  led_t leds_q;
  logic wr_en;

  // Writes only land on word 0xf100, first strobe cycle
  assign wr_en = stb_i && we_i && !ack_q && !adr0_i;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q  <= 1'b0;
      leds_q <= '0;
    end else begin
      ack_q <= stb_i && !ack_q;
      if (wr_en) begin
        if (sel_i[0]) leds_q[7:0]       <= dat_i[7:0];
        if (sel_i[1]) leds_q[LED_W-1:8] <= dat_i[LED_W-1:8];
      end
    end
  end

  // Switches at 0xf100, LED readback at 0xf102
  assign dat_o = adr0_i ? word_t'(leds_q) : word_t'(sw_i);

  assign ack_o  = ack_q;
  assign leds_o = leds_q;

endmodule

/* source/sysctl_port.sv */
// System control byte at port 0x61 with speaker enable output

`timescale 1ns/1ps

module sysctl_port (
  input  logic               clk,
  input  logic               rst_lck,
  input  logic               stb_i,
  input  logic               we_i,
  input  logic [7:0]         dat_hi_i,   // Odd byte of the data bus
  output soc_bus_pkg::word_t dat_o,
  output logic               ack_o,
  output logic               spk_o
);

  import soc_bus_pkg::*;

  logic       ack_q;
  logic [7:0] ctl_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q <= 1'b0;
      ctl_q <= 8'h00;
    end else begin
      ack_q <= stb_i && !ack_q;
      if (stb_i && we_i && !ack_q) ctl_q <= dat_hi_i;
    end
  end

  // Byte lives in the high lane, low lane reads zero
  assign dat_o = word_t'({ctl_q, 8'h00});

  assign ack_o = ack_q;

  // Bit 1 drives the speaker directly, no timer gate here
  assign spk_o = ctl_q[1];

endmodule

/* source/int_controller.sv */
// Eight line edge triggered interrupt controller with fixed priority

`timescale 1ns/1ps

module int_controller (
  input  logic              clk,
  input  logic              rst_lck,
  input  soc_bus_pkg::irq_t irq_i,
  input  logic              inta_i,
  output logic              intr_o,
  output soc_bus_pkg::iid_t iid_o
);

  import soc_bus_pkg::*;

  irq_t irq_q;     // Previous request levels
  logic inta_q;
  irq_t pend_q;
  irq_t irq_rise;
  logic inta_rise;
  irq_t clr;

  assign irq_rise  = irq_i & ~irq_q;
  assign inta_rise = inta_i && !inta_q;

  // Acknowledge retires the line currently being reported
  assign clr = inta_rise ? (irq_t'(1) << iid_o) : '0;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_q  <= '0;
      inta_q <= 1'b0;
      pend_q <= '0;
    end else begin
      irq_q  <= irq_i;
      inta_q <= inta_i;
      pend_q <= (pend_q & ~clr) | irq_rise;  // New edge wins over clear
    end
  end

  // Line 0 is the most urgent
  always_comb begin
    iid_o = '0;
    for (int i = IRQ_N - 1; i >= 0; i--) begin
      if (pend_q[i]) iid_o = iid_t'(i);
    end
  end

  assign intr_o = |pend_q;

endmodule

/* source/bus_read_mux.sv */
// Default responder, acknowledge merge and read data select with vector override

`timescale 1ns/1ps

module bus_read_mux (
  input  logic               clk,
  input  logic               rst_lck,
  input  logic               stb_i,      // Ungated cycle and strobe
  input  soc_bus_pkg::slv_t  slv_sel_i,
  input  soc_bus_pkg::word_t gpio_dat_i,
  input  logic               gpio_ack_i,
  input  soc_bus_pkg::word_t sys_dat_i,
  input  logic               sys_ack_i,
  input  logic               inta_i,
  input  soc_bus_pkg::iid_t  iid_i,
  output soc_bus_pkg::word_t dat_o,
  output logic               ack_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic def_ack_q;

  // Unmapped accesses still complete in one cycle
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      def_ack_q <= 1'b0;
    end else begin
      def_ack_q <= stb_i && slv_sel_i[SLV_DEF] && !def_ack_q;
    end
  end

  assign ack_o = gpio_ack_i || sys_ack_i || def_ack_q;

  always_comb begin
    if (inta_i) begin
      dat_o = INT_VEC_BASE + word_t'(iid_i);  // Vector fetch ignores the bus
    end else if (slv_sel_i[SLV_GPIO]) begin
      dat_o = gpio_dat_i;
    end else if (slv_sel_i[SLV_SYSCTL]) begin
      dat_o = sys_dat_i;
    end else begin
      dat_o = DEF_RDATA;
    end
  end

endmodule

/* source/soc_io_top.sv */
// I/O subsystem top level with decoder, GPIO, system control, interrupts and read mux

`timescale 1ns/1ps

module soc_io_top (
  input  logic               clk,
  input  logic               rst_lck,

  // Bus master side
  input  logic               cyc_i,
  input  logic               stb_i,
  input  logic               we_i,
  input  logic               io_i,
  input  soc_bus_pkg::addr_t adr_i,
  input  soc_bus_pkg::sel_t  sel_i,
  input  soc_bus_pkg::word_t dat_i,
  output soc_bus_pkg::word_t dat_o,
  output logic               ack_o,

  // Interrupts
  input  soc_bus_pkg::irq_t  irq_i,
  input  logic               inta_i,
  output logic               intr_o,

  // Board pins
  input  soc_bus_pkg::sw_t   sw_i,
  output soc_bus_pkg::led_t  leds_o,
  output logic               spk_o
);

  import soc_bus_pkg::*;

  slv_t  slv_sel;
  word_t gpio_dat;
  logic  gpio_ack;
  word_t sys_dat;
  logic  sys_ack;
  iid_t  iid;

  io_addr_decode decode (
    .io_i      (io_i),
    .adr_i     (adr_i),
    .sel_i     (sel_i),
    .slv_sel_o (slv_sel)
  );

  gpio_port gpio (
    .clk     (clk),
    .rst_lck (rst_lck),
    .stb_i   (cyc_i & stb_i & slv_sel[SLV_GPIO]),
    .we_i    (we_i),
    .adr0_i  (adr_i[0]),       // Byte address bit 1
    .sel_i   (sel_i),
    .dat_i   (dat_i),
    .sw_i    (sw_i),
    .dat_o   (gpio_dat),
    .ack_o   (gpio_ack),
    .leds_o  (leds_o)
  );

  sysctl_port sysctl (
    .clk      (clk),
    .rst_lck  (rst_lck),
    .stb_i    (cyc_i & stb_i & slv_sel[SLV_SYSCTL]),
    .we_i     (we_i),
    .dat_hi_i (dat_i[15:8]),
    .dat_o    (sys_dat),
    .ack_o    (sys_ack),
    .spk_o    (spk_o)
  );

  int_controller pic (
    .clk     (clk),
    .rst_lck (rst_lck),
    .irq_i   (irq_i),
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .iid_o   (iid)
  );

  bus_read_mux rdmux (
    .clk        (clk),
    .rst_lck    (rst_lck),
    .stb_i      (cyc_i & stb_i),
    .slv_sel_i  (slv_sel),
    .gpio_dat_i (gpio_dat),
    .gpio_ack_i (gpio_ack),
    .sys_dat_i  (sys_dat),
    .sys_ack_i  (sys_ack),
    .inta_i     (inta_i),
    .iid_i      (iid),
    .dat_o      (dat_o),
    .ack_o      (ack_o)
  );

endmodule

/* tests/soc_io_tb.sv */
// Testbench for the I/O subsystem with bus tasks, LFSR data, assertions and report

`timescale 1ns/1ps

module soc_io_tb;

  import soc_bus_pkg::*;

  localparam int CLK_HALF  = 4;    // 8 ns period
  localparam int ACK_WAIT  = 8;    // Cycles to wait for a handshake

  // Cycles used by each test, an access takes two
  localparam int RESET_CYC = 8;
  localparam int GPIO_CYC  = 24;
  localparam int SYS_CYC   = 16;
  localparam int DEF_CYC   = 24;
  localparam int IRQ_CYC   = 20;
  localparam int LIMIT_CYC = 2 * (RESET_CYC + GPIO_CYC + SYS_CYC + DEF_CYC + IRQ_CYC);

  // Word addresses are byte addresses without bit 0
  localparam addr_t ADR_SW     = addr_t'(20'hF100 >> 1);
  localparam addr_t ADR_LED    = addr_t'(20'hF102 >> 1);
  localparam addr_t ADR_SYSCTL = addr_t'(20'h00060 >> 1);

  logic  clk;
  logic  rst_lck;
  logic  cyc_i;
  logic  stb_i;
  logic  we_i;
  logic  io_i;
  addr_t adr_i;
  sel_t  sel_i;
  word_t dat_i;
  word_t dat_o;
  logic  ack_o;
  irq_t  irq_i;
  logic  inta_i;
  logic  intr_o;
  sw_t   sw_i;
  led_t  leds_o;
  logic  spk_o;

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          cycles;
  int          test_err_base;
  led_t        leds_exp;     // Expected LED register
  logic [7:0]  ctl_exp;      // Expected system control byte

  soc_io_top UUT (
    .clk     (clk),
    .rst_lck (rst_lck),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .we_i    (we_i),
    .io_i    (io_i),
    .adr_i   (adr_i),
    .sel_i   (sel_i),
    .dat_i   (dat_i),
    .dat_o   (dat_o),
    .ack_o   (ack_o),
    .irq_i   (irq_i),
    .inta_i  (inta_i),
    .intr_o  (intr_o),
    .sw_i    (sw_i),
    .leds_o  (leds_o),
    .spk_o   (spk_o)
  );

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT_CYC) begin
      $display("Run stopped after %0d cycles before all tests finished", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // Handshake timing
  ack_after_strobe: assert property (@(posedge clk) disable iff (!rst_lck)
    $rose(cyc_i && stb_i) |=> ack_o)
    else begin
      $display("FAILED at %0t ns: ack_o expected 1 got 0 one cycle after strobe", $time);
      errors++;
    end

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_lck)
    ack_o |=> !ack_o)
    else begin
      $display("FAILED at %0t ns: ack_o expected 0 got 1 after a one cycle pulse", $time);
      errors++;
    end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[14:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    assert (act === exp)
      else begin
        $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, act);
        errors++;
      end
  endtask

  task automatic finish_test(input string name);
    $display("Test %-8s finished with %0d errors", name, errors - test_err_base);
    test_err_base = errors;
  endtask

  // One bus cycle, starts and ends 1 ns after a rising edge
  task automatic bus_access(input logic wr, input logic io, input addr_t adr,
                            input sel_t sel, input word_t wdata, output word_t rdata);
    int waited;
    @(posedge clk);
    #1;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = wr;
    io_i  = io;
    adr_i = adr;
    sel_i = sel;
    dat_i = wdata;
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!ack_o && waited < ACK_WAIT);
    rdata = dat_o;
    if (!ack_o) begin
      $display("Access to word address %h at %0t ns was never acknowledged", adr, $time);
      errors++;
    end
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  // Unmapped access, must not touch LEDs or speaker and must read all ones
  task automatic default_case(input logic io, input addr_t adr, input sel_t sel);
    word_t rd;
    bus_access(1'b1, io, adr, sel, {~ctl_exp, ~leds_exp[7:0]}, rd);
    check_word("leds_o", word_t'(leds_exp), word_t'(leds_o));
    check_word("spk_o", word_t'(ctl_exp[1]), word_t'(spk_o));
    bus_access(1'b0, io, adr, sel, '0, rd);
    check_word("dat_o", 16'hffff, rd);
  endtask

  initial begin
    word_t rd;
    word_t wd;
    sel_t  sel;
    irq_t  pend;
    int    low;
    int    waited;
    $timeformat(-9, 0, "", 0);
    clk     = 1'b0;
    rst_lck = 1'b0;
    cyc_i   = 1'b0;
    stb_i   = 1'b0;
    we_i    = 1'b0;
    io_i    = 1'b0;
    adr_i   = '0;
    sel_i   = '0;
    dat_i   = '0;
    irq_i   = '0;
    inta_i  = 1'b0;
    sw_i    = '0;
    lfsr    = 32'h40088525;
    errors  = 0;
    checks  = 0;
    cycles  = 0;
    test_err_base = 0;
    leds_exp = '0;
    ctl_exp  = 8'h00;

    repeat (RESET_CYC) @(posedge clk);
    #1 rst_lck = 1'b1;
    check_word("ack_o", '0, word_t'(ack_o));
    check_word("intr_o", '0, word_t'(intr_o));
    check_word("spk_o", '0, word_t'(spk_o));
    check_word("leds_o", '0, word_t'(leds_o));
    finish_test("reset");

    // Every lane combination on the LED word
    for (int s = 0; s < 4; s++) begin
      sel = sel_t'(s);
      wd  = rand_bits(16);
      bus_access(1'b1, 1'b1, ADR_SW, sel, wd, rd);
      if (sel[0]) leds_exp[7:0] = wd[7:0];
      if (sel[1]) leds_exp[9:8] = wd[9:8];
      bus_access(1'b0, 1'b1, ADR_LED, 2'b11, '0, rd);
      check_word("dat_o", word_t'(leds_exp), rd);
      check_word("leds_o", word_t'(leds_exp), word_t'(leds_o));
    end
    for (int k = 0; k < 4; k++) begin
      sw_i = sw_t'(rand_bits(SW_W));
      bus_access(1'b0, 1'b1, ADR_SW, 2'b11, '0, rd);
      check_word("dat_o", word_t'(sw_i), rd);
    end
    finish_test("gpio");

    for (int k = 0; k < 4; k++) begin
      wd = rand_bits(16);
      ctl_exp = wd[15:8];          // Port 0x61 is the odd byte
      bus_access(1'b1, 1'b1, ADR_SYSCTL, 2'b10, wd, rd);
      bus_access(1'b0, 1'b1, ADR_SYSCTL, 2'b10, '0, rd);
      check_word("dat_o", {ctl_exp, 8'h00}, rd);
      check_word("spk_o", word_t'(ctl_exp[1]), word_t'(spk_o));
    end
    finish_test("sysctl");

    default_case(1'b1, addr_t'(20'h00080 >> 1), 2'b11);
    default_case(1'b1, addr_t'(20'hF104 >> 1), 2'b11);   // Just past the GPIO window
    default_case(1'b0, ADR_SW, 2'b11);                   // Memory space, not I/O
    default_case(1'b0, ADR_SYSCTL, 2'b10);
    default_case(1'b1, ADR_SYSCTL, 2'b01);               // Port 0x60 low lane
    default_case(1'b1, addr_t'(20'hFFFFE >> 1), 2'b11);
    finish_test("default");

    pend = irq_t'(rand_bits(IRQ_N));
    if (pend == '0) pend = irq_t'(1);
    @(posedge clk);
    #1 irq_i = pend;
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!intr_o && waited < ACK_WAIT);
    check_word("intr_o", word_t'(1'b1), word_t'(intr_o));
    while (pend != '0) begin
      low = 0;
      while (!pend[low]) low++;    // Lowest line wins
      @(posedge clk);
      #1 inta_i = 1'b1;
      @(negedge clk);
      check_word("dat_o", 16'd8 + word_t'(low), dat_o);
      @(posedge clk);
      #1 inta_i = 1'b0;
      pend[low] = 1'b0;
      check_word("intr_o", word_t'(|pend), word_t'(intr_o));
    end
    irq_i = '0;
    finish_test("irq");

    $display("Tests run: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* soc_io_top.f */
source/soc_bus_pkg.sv
source/soc_map_pkg.sv
source/io_addr_decode.sv
source/gpio_port.sv
source/sysctl_port.sv
source/int_controller.sv
source/bus_read_mux.sv
source/soc_io_top.sv
tests/soc_io_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and decide pass or fail from the log

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f soc_io_top.f \
    --top-module soc_io_tb -o soc_io_sim &&
  ./obj_dir/soc_io_sim > sim.log 2>&1 ||
  { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
